//--- hw/ps_demux_pkg.sv
package ps_demux_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  table_addr_t;
	typedef logic [31:0] table_word_t;
	typedef logic [7:0]  start_code_t;
	typedef logic [6:0]  axi_addr_t;     // byte address on the register bus

	localparam start_code_t code_pack   = 8'hba;
	localparam start_code_t code_system = 8'hbb;
	localparam start_code_t code_end    = 8'hb9;

	localparam int entry_words = 8;     // words 0..7 hold stream entries

	localparam table_addr_t addr_scr        = 4'd8;
	localparam table_addr_t addr_mux_rate   = 4'd9;
	localparam table_addr_t addr_rate_bound = 4'd10;
	localparam table_addr_t addr_sys_flags  = 4'd11;

	localparam axi_addr_t  axi_status_addr = 7'h40;
	localparam logic [1:0] resp_okay       = 2'b00;
	localparam logic [1:0] resp_slverr     = 2'b10;

	typedef enum logic [1:0] {
		pack_idle,
		pack_fields,
		pack_done
	} pack_state_t;

	typedef enum logic [2:0] {
		sys_idle,
		sys_fixed,
		sys_entry_id,
		sys_entry_buf,
		sys_done
	} sys_state_t;

	typedef enum logic [1:0] {
		rd_idle,
		rd_wait_grant,
		rd_resp
	} axi_rd_state_t;

	// audio C0..C3 and video E0..E3 only
	function automatic logic is_table_id(byte_t id);
		return (id[7:6] == 2'b11) && (id[4:2] == 3'b000);
	endfunction

	function automatic table_addr_t entry_index(byte_t id);
		return {1'b0, id[5], id[1:0]};
	endfunction

endpackage

//--- hw/start_code_detector.sv
module start_code_detector (
	input  logic                clk,
	input  logic                rst_n,
	input  ps_demux_pkg::byte_t byte_data,
	input  logic                byte_en,
	output logic                pack_start,
	output logic                sys_start,
	output logic                end_seen
);
	import ps_demux_pkg::*;

	logic [23:0] history;       // last three bytes, newest low
	logic        prefix_hit;
	start_code_t code;

	assign prefix_hit = (history == 24'h000001);
	assign code       = byte_data;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			history    <= '1;    // no false prefix out of reset
			pack_start <= 1'b0;
			sys_start  <= 1'b0;
			end_seen   <= 1'b0;
		end else begin
			pack_start <= 1'b0;
			sys_start  <= 1'b0;
			end_seen   <= 1'b0;
			if (byte_en) begin
				history <= {history[15:0], byte_data};
				if (prefix_hit) begin
					// unknown codes just fall through, the shift restarts the hunt
					case (code)
						code_pack:   pack_start <= 1'b1;
						code_system: sys_start  <= 1'b1;
						code_end:    end_seen   <= 1'b1;
						default:     ;
					endcase
				end
			end
		end
	end

endmodule

//--- hw/pack_header_parser.sv
module pack_header_parser (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ps_demux_pkg::byte_t       byte_data,
	input  logic                      byte_en,
	input  logic                      pack_start,
	output logic                      wr_req,
	output ps_demux_pkg::table_addr_t wr_addr,
	output ps_demux_pkg::table_word_t wr_data,
	input  logic                      wr_gnt
);
	import ps_demux_pkg::*;

	pack_state_t state;
	logic [3:0]  byte_cnt;
	logic [3:0]  byte_idx;
	logic        take;
	table_word_t scr;           // scr base bits 31..0
	logic [21:0] mux_rate;

	// a header byte may arrive in the same cycle as the start pulse
	assign take     = byte_en && (pack_start || state == pack_fields);
	assign byte_idx = pack_start ? 4'd0 : byte_cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state    <= pack_idle;
			byte_cnt <= '0;
			wr_req   <= 1'b0;
		end else begin
			if (wr_req && wr_gnt)
				wr_req <= 1'b0;
			if (pack_start) begin
				state    <= pack_fields;
				byte_cnt <= 4'd0;
			end
			if (take) begin
				byte_cnt <= byte_idx + 4'd1;
				if (byte_idx == 4'd6 || byte_idx == 4'd9)
					wr_req <= 1'b1;
				if (byte_idx == 4'd9)
					state <= pack_done;     // stuffing and beyond ignored
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			case (byte_idx)
				4'd0: scr[31:28] <= {byte_data[4:3], byte_data[1:0]};
				4'd1: scr[27:20] <= byte_data;
				4'd2: scr[19:13] <= {byte_data[7:3], byte_data[1:0]};
				4'd3: scr[12:5]  <= byte_data;
				4'd4: scr[4:0]   <= byte_data[7:3];
				4'd6: begin
					mux_rate[21:14] <= byte_data;
					wr_addr         <= addr_scr;
					wr_data         <= scr;
				end
				4'd7: mux_rate[13:6] <= byte_data;
				4'd8: mux_rate[5:0]  <= byte_data[7:2];   // two markers below
				4'd9: begin
					wr_addr <= addr_mux_rate;
					wr_data <= {10'd0, mux_rate};
				end
				default: ;
			endcase
		end
	end

endmodule

//--- hw/system_header_parser.sv
module system_header_parser (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ps_demux_pkg::byte_t       byte_data,
	input  logic                      byte_en,
	input  logic                      sys_start,
	output logic                      wr_req,
	output ps_demux_pkg::table_addr_t wr_addr,
	output ps_demux_pkg::table_word_t wr_data,
	input  logic                      wr_gnt,
	output logic                      entries_clear,
	output logic                      id_err
);
	import ps_demux_pkg::*;

	sys_state_t  state;
	logic [2:0]  fix_cnt;       // position in the eight fixed bytes
	logic [2:0]  fix_idx;
	logic        in_fixed;
	logic        at_id;
	logic        at_buf;
	logic        take;
	logic        counted;       // byte covered by header_length
	logic        last;
	logic        zero_len;
	logic        bad_id;
	logic        done_now;
	logic [15:0] bytes_left;
	logic        buf_part;      // high on the second buffer byte
	logic        flags_pend;
	logic [7:0]  n_stored;
	logic        load_rate;
	logic        load_entry;
	logic        load_flags;
	byte_t       len_hi;
	logic [21:0] rate_bound;
	byte_t       audio_bound;
	byte_t       video_bound;
	byte_t       entry_id;
	logic        buf_scale;
	logic [4:0]  buf_hi;

	assign in_fixed = sys_start || state == sys_fixed;
	assign at_id    = !sys_start && state == sys_entry_id;
	assign at_buf   = !sys_start && state == sys_entry_buf;
	assign take     = byte_en && (in_fixed || at_id || at_buf);
	assign fix_idx  = sys_start ? 3'd0 : fix_cnt;

	assign counted  = take && !(in_fixed && fix_idx < 3'd2);
	assign last     = counted && bytes_left == 16'd1;
	assign zero_len = take && in_fixed && fix_idx == 3'd1 && {len_hi, byte_data} == 16'd0;
	assign bad_id   = take && at_id && !byte_data[7];
	assign done_now = last || zero_len || bad_id;

	assign load_rate  = take && in_fixed && fix_idx == 3'd5;
	assign load_entry = take && at_buf && buf_part && is_table_id(entry_id);
	assign load_flags = flags_pend && !wr_req;    // after any pending write drains

	assign entries_clear = sys_start;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= sys_idle;
			fix_cnt    <= '0;
			bytes_left <= '0;
			buf_part   <= 1'b0;
			flags_pend <= 1'b0;
			n_stored   <= '0;
			wr_req     <= 1'b0;
			id_err     <= 1'b0;
		end else begin
			id_err <= bad_id;
			if (wr_req && wr_gnt)
				wr_req <= 1'b0;
			if (load_rate || load_entry || load_flags)
				wr_req <= 1'b1;
			if (load_flags)
				flags_pend <= 1'b0;
			if (load_entry)
				n_stored <= n_stored + 8'd1;
			if (sys_start) begin
				state      <= sys_fixed;
				fix_cnt    <= 3'd0;
				n_stored   <= '0;
				flags_pend <= 1'b0;
			end
			if (take) begin
				if (in_fixed) begin
					fix_cnt <= fix_idx + 3'd1;
					if (fix_idx == 3'd1)
						bytes_left <= {len_hi, byte_data};
					if (fix_idx == 3'd7)
						state <= sys_entry_id;
				end else if (at_id) begin
					state    <= sys_entry_buf;
					buf_part <= 1'b0;
				end else begin
					buf_part <= 1'b1;
					if (buf_part)
						state <= sys_entry_id;
				end
				if (counted)
					bytes_left <= bytes_left - 16'd1;
				if (done_now) begin
					state      <= sys_done;      // rest of header ignored
					flags_pend <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && in_fixed) begin
			case (fix_idx)
				3'd0: len_hi            <= byte_data;
				3'd2: rate_bound[21:15] <= byte_data[6:0];
				3'd3: rate_bound[14:7]  <= byte_data;
				3'd4: rate_bound[6:0]   <= byte_data[7:1];
				3'd5: audio_bound       <= byte_data;
				3'd6: video_bound       <= byte_data;
				default: ;
			endcase
		end
		if (take && at_id)
			entry_id <= byte_data;
		if (take && at_buf && !buf_part) begin
			buf_scale <= byte_data[5];
			buf_hi    <= byte_data[4:0];
		end
		if (load_rate) begin
			wr_addr <= addr_rate_bound;
			wr_data <= {10'd0, rate_bound};
		end
		if (load_entry) begin
			wr_addr <= entry_index(entry_id);
			wr_data <= {1'b1, 7'd0, entry_id, 2'd0, buf_scale, buf_hi, byte_data};
		end
		if (load_flags) begin
			wr_addr <= addr_sys_flags;
			wr_data <= {n_stored, 8'd0, audio_bound, video_bound};
		end
	end

endmodule

//--- hw/stream_table.sv
module stream_table #(
	parameter int table_depth = 16
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      sys_wr_req,
	input  ps_demux_pkg::table_addr_t sys_wr_addr,
	input  ps_demux_pkg::table_word_t sys_wr_data,
	output logic                      sys_wr_gnt,
	input  logic                      pack_wr_req,
	input  ps_demux_pkg::table_addr_t pack_wr_addr,
	input  ps_demux_pkg::table_word_t pack_wr_data,
	output logic                      pack_wr_gnt,
	input  logic                      entries_clear,
	input  logic                      rd_req,
	input  ps_demux_pkg::table_addr_t rd_addr,
	output logic                      rd_gnt,
	output ps_demux_pkg::table_word_t rd_data
);
	import ps_demux_pkg::*;

	localparam int vld_bits = $clog2(entry_words);

	table_word_t            mem [table_depth];
	logic [entry_words-1:0] valid;
	logic                   wr_en;
	table_addr_t            port_addr;
	table_word_t            port_data;
	table_word_t            rd_word;
	logic                   rd_entry;
	logic                   rd_valid;

	// fixed priority, system parser first
	assign sys_wr_gnt  = sys_wr_req;
	assign pack_wr_gnt = pack_wr_req && !sys_wr_req;
	assign rd_gnt      = rd_req && !sys_wr_req && !pack_wr_req;

	assign wr_en     = sys_wr_gnt || pack_wr_gnt;
	assign port_addr = sys_wr_gnt ? sys_wr_addr : (pack_wr_gnt ? pack_wr_addr : rd_addr);
	assign port_data = sys_wr_gnt ? sys_wr_data : pack_wr_data;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[port_addr] <= port_data;
		end else if (rd_gnt) begin
			rd_word  <= mem[port_addr];
			rd_entry <= port_addr < entry_words;
			rd_valid <= valid[port_addr[vld_bits-1:0]];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid <= '0;
		end else begin
			if (entries_clear)
				valid <= '0;
			if (wr_en && port_addr < entry_words)
				valid[port_addr[vld_bits-1:0]] <= 1'b1;
		end
	end

	assign rd_data = rd_entry ? {rd_valid, rd_word[30:0]} : rd_word;   // entry bit 31 from vector

endmodule

//--- hw/axi_lite_stream_regs.sv
module axi_lite_stream_regs (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ps_demux_pkg::axi_addr_t   awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  ps_demux_pkg::table_word_t wdata,
	input  logic [3:0]                wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  ps_demux_pkg::axi_addr_t   araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output ps_demux_pkg::table_word_t rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready,
	output logic                      rd_req,
	output ps_demux_pkg::table_addr_t rd_addr,
	input  logic                      rd_gnt,
	input  ps_demux_pkg::table_word_t rd_data,
	input  logic                      end_seen,
	input  logic                      id_err
);
	import ps_demux_pkg::*;

	axi_rd_state_t rd_state;
	logic          wr_hs;
	logic          ar_hs;
	logic          rd_capture;    // table word on rd_data now
	logic          end_seen_sticky;
	logic          id_err_sticky;
	logic          ar_table;
	logic          ar_status;
	logic          aw_status;

	assign wr_hs     = awready && awvalid && wvalid;
	assign ar_hs     = arready && arvalid;
	assign ar_table  = !araddr[6];
	assign ar_status = araddr[6:2] == axi_status_addr[6:2];
	assign aw_status = awaddr[6:2] == axi_status_addr[6:2];
	assign bresp     = resp_okay;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			awready         <= 1'b0;
			wready          <= 1'b0;
			bvalid          <= 1'b0;
			end_seen_sticky <= 1'b0;
			id_err_sticky   <= 1'b0;
		end else begin
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready  <= awvalid && wvalid && !awready && !bvalid;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_hs)
				bvalid <= 1'b1;
			if (wr_hs && aw_status && wstrb[0]) begin
				if (wdata[0])
					end_seen_sticky <= 1'b0;
				if (wdata[1])
					id_err_sticky <= 1'b0;
			end
			if (end_seen)
				end_seen_sticky <= 1'b1;   // a new event wins over a clear
			if (id_err)
				id_err_sticky <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state   <= rd_idle;
			arready    <= 1'b1;
			rvalid     <= 1'b0;
			rd_req     <= 1'b0;
			rd_capture <= 1'b0;
		end else begin
			rd_capture <= rd_req && rd_gnt;
			case (rd_state)
				rd_idle: begin
					if (ar_hs) begin
						arready <= 1'b0;
						if (ar_table) begin
							rd_req   <= 1'b1;
							rd_state <= rd_wait_grant;
						end else begin
							rvalid   <= 1'b1;     // status or error answered locally
							rd_state <= rd_resp;
						end
					end
				end
				rd_wait_grant: begin
					if (rd_gnt) begin
						rd_req   <= 1'b0;
						rd_state <= rd_resp;
					end
				end
				rd_resp: begin
					if (rd_capture)
						rvalid <= 1'b1;
					if (rvalid && rready) begin
						rvalid   <= 1'b0;
						arready  <= 1'b1;
						rd_state <= rd_idle;
					end
				end
				default: rd_state <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rd_addr <= araddr[5:2];
			rresp   <= (ar_table || ar_status) ? resp_okay : resp_slverr;
			rdata   <= ar_status ? {30'd0, id_err_sticky, end_seen_sticky} : '0;
		end
		if (rd_capture)
			rdata <= rd_data;
	end

endmodule

//--- hw/ps_demux_top.sv
module ps_demux_top #(
	parameter int table_depth = 16
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  ps_demux_pkg::byte_t       byte_data,
	input  logic                      byte_en,
	input  ps_demux_pkg::axi_addr_t   awaddr,
	input  logic                      awvalid,
	output logic                      awready,
	input  ps_demux_pkg::table_word_t wdata,
	input  logic [3:0]                wstrb,
	input  logic                      wvalid,
	output logic                      wready,
	output logic [1:0]                bresp,
	output logic                      bvalid,
	input  logic                      bready,
	input  ps_demux_pkg::axi_addr_t   araddr,
	input  logic                      arvalid,
	output logic                      arready,
	output ps_demux_pkg::table_word_t rdata,
	output logic [1:0]                rresp,
	output logic                      rvalid,
	input  logic                      rready
);
	import ps_demux_pkg::*;

	logic        pack_start;
	logic        sys_start;
	logic        end_seen;
	logic        pack_wr_req;
	table_addr_t pack_wr_addr;
	table_word_t pack_wr_data;
	logic        pack_wr_gnt;
	logic        sys_wr_req;
	table_addr_t sys_wr_addr;
	table_word_t sys_wr_data;
	logic        sys_wr_gnt;
	logic        entries_clear;
	logic        id_err;
	logic        rd_req;
	table_addr_t rd_addr;
	logic        rd_gnt;
	table_word_t rd_data;

	start_code_detector u_start_code_detector (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_data  (byte_data),
		.byte_en    (byte_en),
		.pack_start (pack_start),
		.sys_start  (sys_start),
		.end_seen   (end_seen)
	);

	pack_header_parser u_pack_header_parser (
		.clk        (clk),
		.rst_n      (rst_n),
		.byte_data  (byte_data),
		.byte_en    (byte_en),
		.pack_start (pack_start),
		.wr_req     (pack_wr_req),
		.wr_addr    (pack_wr_addr),
		.wr_data    (pack_wr_data),
		.wr_gnt     (pack_wr_gnt)
	);

	system_header_parser u_system_header_parser (
		.clk           (clk),
		.rst_n         (rst_n),
		.byte_data     (byte_data),
		.byte_en       (byte_en),
		.sys_start     (sys_start),
		.wr_req        (sys_wr_req),
		.wr_addr       (sys_wr_addr),
		.wr_data       (sys_wr_data),
		.wr_gnt        (sys_wr_gnt),
		.entries_clear (entries_clear),
		.id_err        (id_err)
	);

	stream_table #(
		.table_depth (table_depth)
	) u_stream_table (
		.clk           (clk),
		.rst_n         (rst_n),
		.sys_wr_req    (sys_wr_req),
		.sys_wr_addr   (sys_wr_addr),
		.sys_wr_data   (sys_wr_data),
		.sys_wr_gnt    (sys_wr_gnt),
		.pack_wr_req   (pack_wr_req),
		.pack_wr_addr  (pack_wr_addr),
		.pack_wr_data  (pack_wr_data),
		.pack_wr_gnt   (pack_wr_gnt),
		.entries_clear (entries_clear),
		.rd_req        (rd_req),
		.rd_addr       (rd_addr),
		.rd_gnt        (rd_gnt),
		.rd_data       (rd_data)
	);

	axi_lite_stream_regs u_axi_lite_stream_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wvalid   (wvalid),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.bready   (bready),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.rd_gnt   (rd_gnt),
		.rd_data  (rd_data),
		.end_seen (end_seen),
		.id_err   (id_err)
	);

endmodule

//--- sim/ps_demux_asserts.sv
module ps_demux_asserts (
	input logic                      clk,
	input logic                      rst_n,
	input logic                      rvalid,
	input logic                      rready,
	input ps_demux_pkg::table_word_t rdata,
	input logic                      bvalid,
	input logic                      bready,
	input logic                      pack_wr_req,
	input logic                      pack_wr_gnt
);
	timeunit 1ns;
	timeprecision 1ps;

	int assert_failures = 0;

	// read data held until the host takes it
	assert property (@(posedge clk) disable iff (!rst_n)
		(rvalid && !rready) |=> (rvalid && $stable(rdata)))
	else begin
		$error("rvalid or rdata changed while rready was low");
		assert_failures = assert_failures + 1;
	end

	assert property (@(posedge clk) disable iff (!rst_n) (bvalid && !bready) |=> bvalid)
	else begin
		$error("bvalid dropped while bready was low");
		assert_failures = assert_failures + 1;
	end

	// pack writer waits at most one cycle behind the system parser
	assert property (@(posedge clk) disable iff (!rst_n)
		(pack_wr_req && !pack_wr_gnt) |=> pack_wr_gnt)
	else begin
		$error("pack parser write request waited more than one cycle");
		assert_failures = assert_failures + 1;
	end

endmodule

bind ps_demux_top ps_demux_asserts u_ps_demux_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.rvalid      (rvalid),
	.rready      (rready),
	.rdata       (rdata),
	.bvalid      (bvalid),
	.bready      (bready),
	.pack_wr_req (pack_wr_req),
	.pack_wr_gnt (pack_wr_gnt)
);

//--- sim/ps_demux_tb.sv
module ps_demux_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import ps_demux_pkg::*;

	localparam int n_cases        = 4;
	localparam int max_bytes      = 120;    // per row
	localparam int max_reads      = 14;     // per row
	localparam int timeout_cycles = n_cases * (max_bytes * 4 + max_reads * 8) + 200;

	logic        clk;
	logic        rst_n;
	byte_t       byte_data;
	logic        byte_en;
	axi_addr_t   awaddr;
	logic        awvalid;
	logic        awready;
	table_word_t wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	axi_addr_t   araddr;
	logic        arvalid;
	logic        arready;
	table_word_t rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;

	// stimulus rows, with the expected stored count and id error at the end
	logic [31:0] row_scr    [n_cases] = '{32'h1234_5678, 32'hdead_beef, 32'h0bad_cafe,
		32'h0000_0001};
	logic [21:0] row_mux    [n_cases] = '{22'h01_a2b3, 22'h2a_5a5a, 22'h00_4e20, 22'h3f_fff0};
	logic [21:0] row_rate   [n_cases] = '{22'h03_c350, 22'h12_3456, 22'h00_9c40, 22'h3f_ffff};
	byte_t       row_audio  [n_cases] = '{8'h04, 8'h86, 8'h02, 8'h3f};
	byte_t       row_video  [n_cases] = '{8'he1, 8'h21, 8'h61, 8'hff};
	int          row_nent   [n_cases] = '{2, 4, 3, 4};
	byte_t       row_id     [n_cases][4] = '{
		'{8'hc0, 8'he0, 8'h00, 8'h00},
		'{8'hc1, 8'he2, 8'hbd, 8'hc3},     // bd is skipped
		'{8'he1, 8'h45, 8'hc2, 8'h00},     // 45 has its top bit clear
		'{8'hc4, 8'he3, 8'hc0, 8'he1}
	};
	logic        row_scale  [n_cases][4] = '{'{0, 1, 0, 0}, '{1, 0, 1, 0}, '{0, 0, 1, 0},
		'{1, 1, 0, 0}};
	logic [12:0] row_size   [n_cases][4] = '{
		'{13'h0020, 13'h00e8, 13'h0000, 13'h0000},
		'{13'h1fff, 13'h0100, 13'h0400, 13'h0abc},
		'{13'h0080, 13'h0011, 13'h0200, 13'h0000},
		'{13'h0001, 13'h1000, 13'h0333, 13'h00ff}
	};
	int          row_stored [n_cases] = '{2, 3, 1, 3};
	logic        row_err    [n_cases] = '{0, 0, 1, 0};

	byte_t       stream_q [$];
	table_word_t exp_word [12];
	logic [7:0]  exp_valid;
	logic [31:0] rng_state = 32'h68f8;
	int          cycle_count = 0;

	ps_demux_top #(
		.table_depth (16)
	) u_ps_demux_top (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout: the test did not finish within %0d clock cycles", cycle_count);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation timeout");
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic int draw_small();
		rng_state = xorshift32(rng_state);
		return int'(rng_state[1:0]);     // 0..3
	endfunction

	task automatic compare_word(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch on %s", what);
		end
	endtask

	task automatic push_start_code(input start_code_t code);
		stream_q.push_back(8'h00);
		stream_q.push_back(8'h00);
		stream_q.push_back(8'h01);
		stream_q.push_back(code);
	endtask

	task automatic push_pack_header(input int r);
		logic [31:0] s;
		logic [21:0] m;
		s = row_scr[r];
		m = row_mux[r];
		push_start_code(code_pack);
		stream_q.push_back({2'b01, 1'b0, s[31:30], 1'b1, s[29:28]});   // scr bit 32 zero
		stream_q.push_back(s[27:20]);
		stream_q.push_back({s[19:15], 1'b1, s[14:13]});
		stream_q.push_back(s[12:5]);
		stream_q.push_back({s[4:0], 1'b1, 2'b00});
		stream_q.push_back(8'h01);           // extension zero, marker
		stream_q.push_back(m[21:14]);
		stream_q.push_back(m[13:6]);
		stream_q.push_back({m[5:0], 2'b11});
		stream_q.push_back(8'hf8);           // no stuffing
	endtask

	task automatic push_system_header(input int r);
		logic [15:0] len;
		logic [21:0] rb;
		len = 16'(6 + 3 * row_nent[r]);
		rb  = row_rate[r];
		push_start_code(code_system);
		stream_q.push_back(len[15:8]);
		stream_q.push_back(len[7:0]);
		stream_q.push_back({1'b1, rb[21:15]});
		stream_q.push_back(rb[14:7]);
		stream_q.push_back({rb[6:0], 1'b1});
		stream_q.push_back(row_audio[r]);
		stream_q.push_back(row_video[r]);
		stream_q.push_back(8'h7f);
		for (int k = 0; k < row_nent[r]; k++) begin
			stream_q.push_back(row_id[r][k]);
			stream_q.push_back({2'b11, row_scale[r][k], row_size[r][k][12:8]});
			stream_q.push_back(row_size[r][k][7:0]);
		end
	endtask

	task automatic send_stream();
		int gap;
		while (stream_q.size() > 0) begin
			byte_data = stream_q.pop_front();
			byte_en   = 1'b1;
			@(negedge clk);
			byte_en = 1'b0;
			gap     = draw_small();
			repeat (gap) @(negedge clk);
		end
	endtask

	// expected table contents after one row
	task automatic predict_row(input int r);
		byte_t      id;
		logic [2:0] idx;
		logic       stop;
		exp_valid = '0;
		stop      = 1'b0;
		for (int k = 0; k < row_nent[r]; k++) begin
			id = row_id[r][k];
			if (!stop && !id[7]) begin
				stop = 1'b1;
			end else if (!stop && ((id >= 8'hc0 && id <= 8'hc3) ||
				(id >= 8'he0 && id <= 8'he3))) begin
				idx            = {id[5], id[1:0]};
				exp_word[idx]  = {1'b1, 7'd0, id, 2'd0, row_scale[r][k], row_size[r][k]};
				exp_valid[idx] = 1'b1;
			end
		end
		exp_word[8]  = row_scr[r];
		exp_word[9]  = {10'd0, row_mux[r]};
		exp_word[10] = {10'd0, row_rate[r]};
		exp_word[11] = {8'(row_stored[r]), 8'd0, row_audio[r], row_video[r]};
	endtask

	task automatic axi_read(input axi_addr_t addr, output table_word_t data,
		output logic [1:0] resp);
		int hold;
		araddr  = addr;
		arvalid = 1'b1;
		while (!arready) @(negedge clk);
		@(negedge clk);                      // ar handshake on the edge before
		arvalid = 1'b0;
		hold    = draw_small();
		repeat (hold) @(negedge clk);        // rready back-pressure
		rready = 1'b1;
		while (!rvalid) @(negedge clk);
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic axi_write(input axi_addr_t addr, input table_word_t data,
		output logic [1:0] resp);
		int hold;
		awaddr  = addr;
		awvalid = 1'b1;
		wdata   = data;
		wstrb   = 4'hf;
		wvalid  = 1'b1;
		while (!(awready && wready)) @(negedge clk);
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		hold    = 1 + draw_small();
		repeat (hold) @(negedge clk);        // bready back-pressure
		bready = 1'b1;
		while (!bvalid) @(negedge clk);
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic read_expect(input axi_addr_t addr, input table_word_t exp,
		input table_word_t mask, input logic [1:0] exp_resp, input string what);
		table_word_t data;
		logic [1:0]  resp;
		axi_read(addr, data, resp);
		compare_word({what, " rresp"}, {30'd0, resp}, {30'd0, exp_resp});
		compare_word(what, data & mask, exp & mask);
	endtask

	initial begin
		logic [1:0] resp;
		rst_n     = 1'b0;
		byte_data = '0;
		byte_en   = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int r = 0; r < n_cases; r++) begin
			push_pack_header(r);
			push_system_header(r);
			push_start_code(code_end);
			send_stream();
			repeat (2) @(negedge clk);       // last field readable from the second clock
			predict_row(r);
			for (int w = 8; w < 12; w++)
				read_expect(axi_addr_t'(w * 4), exp_word[w], '1, resp_okay,
					$sformatf("row %0d word %0d", r, w));
			for (int w = 0; w < 8; w++) begin
				if (exp_valid[w])
					read_expect(axi_addr_t'(w * 4), exp_word[w], '1, resp_okay,
						$sformatf("row %0d entry %0d", r, w));
				else
					read_expect(axi_addr_t'(w * 4), '0, 32'h8000_0000, resp_okay,
						$sformatf("row %0d entry %0d valid bit", r, w));
			end
			read_expect(axi_status_addr, {30'd0, row_err[r], 1'b1}, '1, resp_okay,
				$sformatf("row %0d status", r));
			axi_write(axi_status_addr, 32'h3, resp);   // clear both sticky bits
			compare_word("status write bresp", {30'd0, resp}, {30'd0, resp_okay});
			read_expect(axi_status_addr, '0, '1, resp_okay,
				$sformatf("row %0d status after clear", r));
		end
		read_expect(7'h44, '0, '1, resp_slverr, "unmapped address");

		if (u_ps_demux_top.u_ps_demux_asserts.assert_failures == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("bus protocol assertions failed during the run");
			$display("TEST RESULT: FAIL");
			$fatal(1, "assertion failures");
		end
	end

endmodule

//--- project.f
hw/ps_demux_pkg.sv
hw/start_code_detector.sv
hw/pack_header_parser.sv
hw/system_header_parser.sv
hw/stream_table.sv
hw/axi_lite_stream_regs.sv
hw/ps_demux_top.sv
sim/ps_demux_asserts.sv
sim/ps_demux_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module ps_demux_tb -f project.f -o ps_demux_sim
	@out="$$(./obj_dir/ps_demux_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
